//--- common/decode_if.sv
// Decoded instruction fields and operands
// Shared by decoder, register file, execution units and writeback
`timescale 1ns/1ps

interface decode_if;

    rv_isa_pkg::op_class_t op_class;
    rv_isa_pkg::funct3_t   funct3;
    exec_pkg::alu_op_t     alu_op;
    rv_isa_pkg::word_t     imm;       // Sign-extended by format
    rv_isa_pkg::reg_idx_t  rs1_idx;
    rv_isa_pkg::reg_idx_t  rs2_idx;
    rv_isa_pkg::reg_idx_t  rd_idx;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data;
    rv_isa_pkg::word_t     pc;        // PC of the current instruction

    modport decoder (output op_class, funct3, alu_op, imm, rs1_idx, rs2_idx, rd_idx);
    modport regfile (input rs1_idx, rs2_idx, output rs1_data, rs2_data);
    modport exec (input op_class, funct3, alu_op, imm, rs1_data, rs2_data, pc);
    modport writeback (input op_class, rd_idx, output pc);

endinterface

//--- common/exec_pkg.sv
// Execution-side definitions
// ALU operation codes and the default reset PC
package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Boot address of the reference platform
    localparam rv_isa_pkg::word_t RESET_PC_DEFAULT = 32'h8000_0000;

endpackage

//--- common/rv_isa_pkg.sv
// RV32I encoding definitions
// Word and index types, opcode and funct3 values, instruction classes
package rv_isa_pkg;

    typedef logic [31:0] word_t;     // Data word, PC or instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes handled by the core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Instruction classes after decode
    typedef enum logic [2:0] {
        OP_REG,      // Register-register arithmetic
        OP_IMM,      // Register-immediate arithmetic
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_ILLEGAL   // Anything outside the kept set
    } op_class_t;

endpackage

//--- core/alu_unit.sv
// ALU unit
// Operand select by instruction class and the arithmetic result
`timescale 1ns/1ps

module alu_unit (
    decode_if.exec            dec,
    output rv_isa_pkg::word_t alu_result
);

    rv_isa_pkg::word_t op_a;
    rv_isa_pkg::word_t op_b;
    logic [4:0]        shamt;

    always_comb begin
        case (dec.op_class)
            rv_isa_pkg::OP_LUI:   op_a = '0;
            rv_isa_pkg::OP_AUIPC: op_a = dec.pc;
            default:              op_a = dec.rs1_data;
        endcase
    end

    always_comb begin
        case (dec.op_class)
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: op_b = dec.imm;
            default: op_b = dec.rs2_data;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            exec_pkg::ALU_ADD:  alu_result = op_a + op_b;
            exec_pkg::ALU_SUB:  alu_result = op_a - op_b;
            exec_pkg::ALU_SLL:  alu_result = op_a << shamt;
            exec_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            exec_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            exec_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            exec_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            exec_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            exec_pkg::ALU_OR:   alu_result = op_a | op_b;
            default:            alu_result = op_a & op_b;
        endcase
    end

endmodule

//--- core/branch_unit.sv
// Branch unit
// Conditional branch compare and jump target for branches, JAL and JALR
`timescale 1ns/1ps

module branch_unit (
    decode_if.exec            dec,
    output logic              taken,
    output rv_isa_pkg::word_t target
);

    rv_isa_pkg::word_t jalr_sum;
    logic              cond;

    assign jalr_sum = dec.rs1_data + dec.imm;

    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_BEQ:  cond = dec.rs1_data == dec.rs2_data;
            rv_isa_pkg::F3_BNE:  cond = dec.rs1_data != dec.rs2_data;
            rv_isa_pkg::F3_BLT:  cond = $signed(dec.rs1_data) < $signed(dec.rs2_data);
            rv_isa_pkg::F3_BGE:  cond = $signed(dec.rs1_data) >= $signed(dec.rs2_data);
            rv_isa_pkg::F3_BLTU: cond = dec.rs1_data < dec.rs2_data;
            rv_isa_pkg::F3_BGEU: cond = dec.rs1_data >= dec.rs2_data;
            default:             cond = 1'b0;  // Reserved codes fall through
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = dec.pc + dec.imm;
        case (dec.op_class)
            rv_isa_pkg::OP_BRANCH: taken = cond;
            rv_isa_pkg::OP_JAL:    taken = 1'b1;
            rv_isa_pkg::OP_JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[31:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

//--- core/core_top.sv
// RV32I integer execute core
// One instruction per inst_valid strobe, retired with registered outputs
`timescale 1ns/1ps

module core_top #(
    parameter rv_isa_pkg::word_t RESET_PC = exec_pkg::RESET_PC_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  rv_isa_pkg::word_t    inst,
    output logic                 retire_valid,
    output rv_isa_pkg::word_t    retire_pc,
    output logic                 wb_en,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output rv_isa_pkg::word_t    wb_data,
    output rv_isa_pkg::word_t    next_pc,
    output logic                 illegal
);

    decode_if dec ();

    rv_isa_pkg::word_t    alu_result;
    rv_isa_pkg::word_t    target;
    logic                 taken;
    logic                 wr_en;
    rv_isa_pkg::reg_idx_t wr_idx;
    rv_isa_pkg::word_t    wr_data;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .dec     (dec)
    );

    alu_unit u_alu (
        .dec        (dec),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .dec    (dec),
        .taken  (taken),
        .target (target)
    );

    writeback_unit #(
        .RESET_PC (RESET_PC)
    ) u_writeback (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .alu_result   (alu_result),
        .target       (target),
        .taken        (taken),
        .dec          (dec),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .wb_en        (wb_en),
        .illegal      (illegal),
        .retire_pc    (retire_pc),
        .next_pc      (next_pc),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd)
    );

endmodule

//--- core/inst_decoder.sv
// Instruction decoder
// Field slicing, opcode classification, immediate build and ALU op select
`timescale 1ns/1ps

module inst_decoder (
    input  rv_isa_pkg::word_t inst,
    decode_if.decoder         dec
);

    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::op_class_t op_class;
    logic [6:0]            funct7;

    assign opcode      = inst[6:0];
    assign funct7      = inst[31:25];
    assign dec.rd_idx  = inst[11:7];
    assign dec.funct3  = inst[14:12];
    assign dec.rs1_idx = inst[19:15];
    assign dec.rs2_idx = inst[24:20];
    assign dec.op_class = op_class;

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP:     op_class = rv_isa_pkg::OP_REG;
            rv_isa_pkg::OPC_OP_IMM: op_class = rv_isa_pkg::OP_IMM;
            rv_isa_pkg::OPC_LUI:    op_class = rv_isa_pkg::OP_LUI;
            rv_isa_pkg::OPC_AUIPC:  op_class = rv_isa_pkg::OP_AUIPC;
            rv_isa_pkg::OPC_JAL:    op_class = rv_isa_pkg::OP_JAL;
            rv_isa_pkg::OPC_JALR:   op_class = rv_isa_pkg::OP_JALR;
            rv_isa_pkg::OPC_BRANCH: op_class = rv_isa_pkg::OP_BRANCH;
            default:                op_class = rv_isa_pkg::OP_ILLEGAL;  // Loads, stores, system
        endcase
    end

    // Immediate by encoding format
    always_comb begin
        case (op_class)
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_JALR:
                dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::OP_BRANCH:
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC:
                dec.imm = {inst[31:12], 12'b0};
            rv_isa_pkg::OP_JAL:
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = exec_pkg::ALU_ADD;  // Address and upper-immediate adds
        if (op_class == rv_isa_pkg::OP_REG || op_class == rv_isa_pkg::OP_IMM) begin
            case (inst[14:12])
                3'b000: begin
                    // ADDI has no subtract form
                    if (op_class == rv_isa_pkg::OP_REG && funct7[5]) begin
                        dec.alu_op = exec_pkg::ALU_SUB;
                    end
                end
                3'b001:  dec.alu_op = exec_pkg::ALU_SLL;
                3'b010:  dec.alu_op = exec_pkg::ALU_SLT;
                3'b011:  dec.alu_op = exec_pkg::ALU_SLTU;
                3'b100:  dec.alu_op = exec_pkg::ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
                3'b110:  dec.alu_op = exec_pkg::ALU_OR;
                default: dec.alu_op = exec_pkg::ALU_AND;
            endcase
        end
    end

endmodule

//--- core/reg_file.sv
// Integer register file, 32 x 32 bits
// Two combinational read ports, one clocked write port
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  rv_isa_pkg::reg_idx_t wr_idx,
    input  rv_isa_pkg::word_t    wr_data,
    decode_if.regfile            dec
);

    rv_isa_pkg::word_t regs [32];

    // x0 is never written by the writeback unit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign dec.rs1_data = regs[dec.rs1_idx];
    assign dec.rs2_data = regs[dec.rs2_idx];

endmodule

//--- core/writeback_unit.sv
// Writeback unit
// PC register, register write select and registered retire outputs
`timescale 1ns/1ps

module writeback_unit #(
    parameter rv_isa_pkg::word_t RESET_PC = exec_pkg::RESET_PC_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  rv_isa_pkg::word_t    alu_result,
    input  rv_isa_pkg::word_t    target,
    input  logic                 taken,
    decode_if.writeback          dec,
    output logic                 wr_en,
    output rv_isa_pkg::reg_idx_t wr_idx,
    output rv_isa_pkg::word_t    wr_data,
    output logic                 retire_valid,
    output logic                 wb_en,
    output logic                 illegal,
    output rv_isa_pkg::word_t    retire_pc,
    output rv_isa_pkg::word_t    next_pc,
    output rv_isa_pkg::word_t    wb_data,
    output rv_isa_pkg::reg_idx_t wb_rd
);

    rv_isa_pkg::word_t pc_q;
    rv_isa_pkg::word_t pc_plus4;
    rv_isa_pkg::word_t pc_next;
    logic              writes_rd;

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = taken ? target : pc_plus4;  // Illegal is never taken
    assign dec.pc   = pc_q;

    always_comb begin
        case (dec.op_class)
            rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
                writes_rd = 1'b1;
                wr_data   = pc_plus4;   // Link address
            end
            rv_isa_pkg::OP_REG, rv_isa_pkg::OP_IMM,
            rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
                writes_rd = 1'b1;
                wr_data   = alu_result;
            end
            default: begin
                writes_rd = 1'b0;
                wr_data   = '0;
            end
        endcase
    end

    assign wr_idx = dec.rd_idx;
    assign wr_en  = inst_valid && writes_rd && (dec.rd_idx != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q         <= RESET_PC;
            retire_valid <= 1'b0;
            wb_en        <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            wb_en        <= wr_en;
            illegal      <= inst_valid && (dec.op_class == rv_isa_pkg::OP_ILLEGAL);
            if (inst_valid) begin
                pc_q <= pc_next;
            end
        end
    end

    // Retire payload, meaningful only with retire_valid
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire_pc <= pc_q;
            next_pc   <= pc_next;
            wb_rd     <= wr_idx;
            wb_data   <= wr_data;
        end
    end

endmodule

//--- flist.f
common/rv_isa_pkg.sv
common/exec_pkg.sv
common/decode_if.sv
core/inst_decoder.sv
core/reg_file.sv
core/alu_unit.sv
core/branch_unit.sv
core/writeback_unit.sv
core/core_top.sv
verification/core_tb_chk.sv
verification/core_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the execute core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module core_tb -f flist.f -o core_tb_sim &&
./obj_dir/core_tb_sim || exit 1

//--- verification/core_tb.sv
// Testbench for the RV32I execute core
// Random instruction stimulus checked against a reference model
`timescale 1ns/1ps

module core_tb;

    typedef logic [31:0][31:0] reg_array_t;
    typedef struct packed {
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::word_t    npc;
        logic                 wen;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    data;
        logic                 ill;
    } expect_t;

    localparam rv_isa_pkg::word_t BOOT_PC = 32'h0000_1000;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 inst_valid;
    rv_isa_pkg::word_t    inst;
    logic                 retire_valid;
    rv_isa_pkg::word_t    retire_pc;
    logic                 wb_en;
    rv_isa_pkg::reg_idx_t wb_rd;
    rv_isa_pkg::word_t    wb_data;
    rv_isa_pkg::word_t    next_pc;
    logic                 illegal;

    reg_array_t        model_regs;   // Architectural state seen by the model
    rv_isa_pkg::word_t model_pc;
    expect_t           exp_q[$];
    string             name_q[$];

    core_top #(.RESET_PC(BOOT_PC)) uut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .next_pc      (next_pc),
        .illegal      (illegal)
    );

    always #4 clk = ~clk;

    function automatic rv_isa_pkg::word_t enc_r(logic [6:0] f7, rv_isa_pkg::reg_idx_t rs2,
            rv_isa_pkg::reg_idx_t rs1, rv_isa_pkg::funct3_t f3, rv_isa_pkg::reg_idx_t rd,
            rv_isa_pkg::opcode_t opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t enc_i(logic [11:0] imm, rv_isa_pkg::reg_idx_t rs1,
            rv_isa_pkg::funct3_t f3, rv_isa_pkg::reg_idx_t rd, rv_isa_pkg::opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t alu_calc(rv_isa_pkg::funct3_t f3, logic alt,
            logic is_reg, rv_isa_pkg::word_t x, rv_isa_pkg::word_t y);
        rv_isa_pkg::word_t r;
        case (f3)
            3'd0: r = (is_reg && alt) ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = {31'b0, $signed(x) < $signed(y)};
            3'd3: r = {31'b0, x < y};
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt) r = $signed(x) >>> y[4:0];
                else r = x >> y[4:0];
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(rv_isa_pkg::funct3_t f3, rv_isa_pkg::word_t x,
            rv_isa_pkg::word_t y);
        case (f3)
            rv_isa_pkg::F3_BEQ:  return x == y;
            rv_isa_pkg::F3_BNE:  return x != y;
            rv_isa_pkg::F3_BLT:  return $signed(x) < $signed(y);
            rv_isa_pkg::F3_BGE:  return $signed(x) >= $signed(y);
            rv_isa_pkg::F3_BLTU: return x < y;
            rv_isa_pkg::F3_BGEU: return x >= y;
            default:             return 1'b0;
        endcase
    endfunction

    // Expected retire for one instruction from the RV32I rules
    function automatic expect_t ref_model(reg_array_t regs, rv_isa_pkg::word_t pc,
            rv_isa_pkg::word_t ins);
        expect_t           e;
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        rv_isa_pkg::word_t i_imm;
        logic              wr;
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        e = '0;
        e.pc = pc;
        e.rd = ins[11:7];
        e.npc = pc + 32'd4;
        wr = 1'b1;
        case (ins[6:0])
            rv_isa_pkg::OPC_OP:     e.data = alu_calc(ins[14:12], ins[30], 1'b1, a, b);
            rv_isa_pkg::OPC_OP_IMM: e.data = alu_calc(ins[14:12], ins[30], 1'b0, a, i_imm);
            rv_isa_pkg::OPC_LUI:    e.data = {ins[31:12], 12'b0};
            rv_isa_pkg::OPC_AUIPC:  e.data = pc + {ins[31:12], 12'b0};
            rv_isa_pkg::OPC_JAL: begin
                e.data = pc + 32'd4;
                e.npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_isa_pkg::OPC_JALR: begin
                e.data = pc + 32'd4;
                e.npc = (a + i_imm) & ~32'd1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_cond(ins[14:12], a, b))
                    e.npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: begin
                wr = 1'b0;
                e.ill = 1'b1;
            end
        endcase
        e.wen = wr && (e.rd != 5'd0);
        return e;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string test, input string field,
            input rv_isa_pkg::word_t exp_v, input rv_isa_pkg::word_t act_v);
        assert (act_v === exp_v)
        else stop_on_error($sformatf("Fail %s %s: expected %h actual %h",
                                     test, field, exp_v, act_v));
    endtask

    task automatic issue(input string test, input rv_isa_pkg::word_t ins);
        expect_t e;
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst = ins;
        e = ref_model(model_regs, model_pc, ins);
        exp_q.push_back(e);
        name_q.push_back(test);
        if (e.wen) model_regs[e.rd] = e.data;
        model_pc = e.npc;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    // Compare each retire with the oldest expected entry
    initial begin : compare_proc
        expect_t e;
        string   nm;
        int      waited;
        forever begin
            if (exp_q.size() == 0) begin
                @(negedge clk);
            end else begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (!retire_valid && waited < 10);
                if (!retire_valid) stop_on_error("No retire within 10 cycles of an issue");
                e = exp_q.pop_front();
                nm = name_q.pop_front();
                check_val(nm, "retire_pc", e.pc, retire_pc);
                check_val(nm, "next_pc", e.npc, next_pc);
                check_val(nm, "illegal", 32'(e.ill), 32'(illegal));
                check_val(nm, "wb_en", 32'(e.wen), 32'(wb_en));
                check_val(nm, "wb_rd", 32'(e.rd), 32'(wb_rd));
                if (e.wen) check_val(nm, "wb_data", e.data, wb_data);
            end
        end
    end

    initial begin
        int                   waited;
        rv_isa_pkg::word_t    v;
        rv_isa_pkg::word_t    w;
        rv_isa_pkg::funct3_t  f3;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        logic [12:0]          b_imm;
        logic [20:0]          j_imm;
        logic                 alt;
        void'($urandom(32'h621e_806c));
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        model_regs = '0;
        model_pc = BOOT_PC;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Retire flags quiet out of reset
        check_val("reset", "retire_valid", 32'd0, 32'(retire_valid));
        check_val("reset", "wb_en", 32'd0, 32'(wb_en));
        check_val("reset", "illegal", 32'd0, 32'(illegal));

        for (int i = 0; i < 32; i++)   // Every register reads zero
            issue("reset_zero", enc_r(7'd0, 5'(31 - i), 5'(i), 3'd0, 5'd1, rv_isa_pkg::OPC_OP));
        for (int r = 1; r < 32; r++) begin
            v = $urandom();
            issue("lui", {v[31:12], 5'(r), rv_isa_pkg::OPC_LUI});
            issue("addi_seed", enc_i(v[11:0], 5'(r), 3'd0, 5'(r), rv_isa_pkg::OPC_OP_IMM));
        end

        repeat (300) begin
            v = $urandom();
            w = $urandom();
            f3 = v[2:0];
            rs1 = v[9:5];
            rs2 = v[14:10];
            alt = v[3] && (f3 == 3'd0 || f3 == 3'd5);
            if (v[31:29] == 3'd0) idle();  // Occasional gap
            if (v[4])
                issue("alu_reg", enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, v[19:15],
                                       rv_isa_pkg::OPC_OP));
            else if (f3 == 3'd1 || f3 == 3'd5)
                issue("alu_shift_imm", enc_i({1'b0, alt, 5'b0, rs2}, rs1, f3, v[19:15],
                                             rv_isa_pkg::OPC_OP_IMM));
            else
                issue("alu_imm", enc_i(w[11:0], rs1, f3, v[19:15], rv_isa_pkg::OPC_OP_IMM));
        end

        repeat (20) begin
            v = $urandom();
            issue("auipc", {v[31:12], v[11:7], rv_isa_pkg::OPC_AUIPC});
            issue("x0_write", enc_i(v[11:0], v[16:12], v[22:20], 5'd0, rv_isa_pkg::OPC_OP_IMM));
            issue("lui_x0", {v[31:12], 5'd0, rv_isa_pkg::OPC_LUI});
        end

        repeat (60) begin
            v = $urandom();
            w = $urandom();
            rs1 = v[9:5];
            rs2 = v[3] ? rs1 : v[14:10];   // Equal operands half the time
            f3 = v[2:0];
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            b_imm = {w[12:1], 1'b0};
            j_imm = {w[31:12], 1'b0};
            issue("branch", {b_imm[12], b_imm[10:5], rs2, rs1, f3, b_imm[4:1], b_imm[11],
                             rv_isa_pkg::OPC_BRANCH});
            issue("jal", {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], v[19:15],
                          rv_isa_pkg::OPC_JAL});
            issue("jalr", enc_i(w[11:0], v[24:20], 3'd0, v[29:25], rv_isa_pkg::OPC_JALR));
        end

        // x5 from x6, then x6 from x5, each one cycle after the write
        repeat (20) begin
            issue("back_to_back", enc_i(12'd3, 5'd6, 3'd0, 5'd5, rv_isa_pkg::OPC_OP_IMM));
            issue("back_to_back", enc_r(7'd0, 5'd5, 5'd6, 3'd0, 5'd6, rv_isa_pkg::OPC_OP));
        end

        for (int i = 0; i < 30; i++) begin
            v = $urandom();
            case (i % 3)
                0: issue("illegal_load", {v[31:7], 7'b0000011});
                1: issue("illegal_store", {v[31:7], 7'b0100011});
                default: issue("illegal_system", {v[31:7], 7'b1110011});
            endcase
        end
        idle();

        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_error("Retires missing at the end of the run");
        end
    end

endmodule

//--- verification/core_tb_chk.sv
// Retire protocol assertions for the execute core
`timescale 1ns/1ps

module core_tb_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 inst_valid,
    input logic                 retire_valid,
    input logic                 wb_en,
    input logic                 illegal,
    input rv_isa_pkg::reg_idx_t wb_rd
);

    retire_follows_valid: assert property (@(posedge clk) disable iff (reset)
        retire_valid == $past(inst_valid))
        else $error("retire_valid does not follow inst_valid by one cycle");

    write_needs_retire: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> retire_valid)
        else $error("wb_en high without retire_valid");

    write_needs_rd: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> (wb_rd != 5'd0))
        else $error("wb_en high with rd zero");

    illegal_no_write: assert property (@(posedge clk) disable iff (reset)
        illegal |-> !wb_en)
        else $error("illegal instruction wrote a register");

endmodule

bind core_top core_tb_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .wb_en        (wb_en),
    .illegal      (illegal),
    .wb_rd        (wb_rd)
);
